//--- verilog.f
logic/ps2_pkg.sv
logic/timer_pkg.sv
logic/ps2_tick_gen.sv
logic/ps2_interval_timer.sv
logic/ps2_host_tx.sv
logic/ps2_host_send_top.sv
testbench/ps2_device_model.sv
testbench/tb_ps2_host_send.sv

//--- Makefile
# Verilator lint, build and run for the PS/2 host send testbench

TOP := tb_ps2_host_send
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

obj_dir/V$(TOP): verilog.f $(wildcard logic/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

# pass only when the log holds the pass line
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_ps2_host_send.sv
////////////////////////////////////////////////////////////
// PS/2 host send testbench
// random commands, reference checks, request order, watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_ps2_host_send;
	import ps2_pkg::*;

	localparam int  NUM_RANDOM  = 12;
	localparam int  NUM_FRAMES  = 14;
	localparam int  FRAME_NS    = 3_000_000;
	// 3 ms of 10 ns cycles
	localparam int  DONE_LIMIT  = FRAME_NS / 10;
	localparam time HOLD_MIN_NS = 119_000;
	localparam time HOLD_MAX_NS = 121_000;

	logic       clk_main_loop;
	logic       rst_n;
	logic [7:0] cmd_byte;
	logic       send;
	logic       done;
	tx_result_e result;
	logic       busy;
	logic       ps2_clk_drive_low;
	logic       ps2_data_drive_low;

	// open-drain bus, low when either side pulls
	wire ps2_clk_line;
	wire ps2_data_line;

	logic       model_clk_low;
	logic       model_data_low;
	logic       ack_low;
	logic       silent;
	logic [7:0] cap_byte;
	logic       cap_parity;
	logic       cap_stop;
	int         frame_cnt;

	// latched on every done pulse
	int         done_cnt = 0;
	tx_result_e res_at_done = RES_OK;
	logic       clk_low_at_done = 1'b0;
	logic       data_low_at_done = 1'b0;

	assign ps2_clk_line  = ~(ps2_clk_drive_low | model_clk_low);
	assign ps2_data_line = ~(ps2_data_drive_low | model_data_low);

	ps2_host_send_top dut0 (
		.clk_main_loop      (clk_main_loop),
		.rst_n              (rst_n),
		.cmd_byte           (cmd_byte),
		.send               (send),
		.done               (done),
		.result             (result),
		.busy               (busy),
		.ps2_clk_in         (ps2_clk_line),
		.ps2_data_in        (ps2_data_line),
		.ps2_clk_drive_low  (ps2_clk_drive_low),
		.ps2_data_drive_low (ps2_data_drive_low)
	);

	ps2_device_model u_device (
		.ps2_clk        (ps2_clk_line),
		.ps2_data       (ps2_data_line),
		.ack_low        (ack_low),
		.silent         (silent),
		.clk_drive_low  (model_clk_low),
		.data_drive_low (model_data_low),
		.cap_byte       (cap_byte),
		.cap_parity     (cap_parity),
		.cap_stop       (cap_stop),
		.frame_cnt      (frame_cnt)
	);

	initial clk_main_loop = 1'b0;
	always #5 clk_main_loop = ~clk_main_loop;

	// pre-edge values belong to the done cycle
	always @(posedge clk_main_loop) begin
		if (done) begin
			done_cnt         <= done_cnt + 1;
			res_at_done      <= result;
			clk_low_at_done  <= ps2_clk_drive_low;
			data_low_at_done <= ps2_data_drive_low;
		end
	end

	////////////////////////////////////////////////////////////
	// failure handling and compare tasks
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_result(input string name, input tx_result_e got,
			input tx_result_e exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	// parity bit makes the count of ones odd
	function automatic logic odd_parity(input logic [7:0] b);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++) begin
			if (b[0]) begin
				ones++;
			end
			b = b >> 1;
		end
		return (ones % 2 == 0);
	endfunction

	function automatic tx_result_e expected_result(input logic quiet, input logic ack);
		if (quiet) begin
			return RES_TIMEOUT;
		end else if (ack) begin
			return RES_OK;
		end
		return RES_NO_ACK;
	endfunction

	// inhibit, then data low under the held clock, then release
	task automatic watch_request(input logic quiet);
		time t_low;
		time t_release;
		while (!ps2_clk_drive_low) begin
			@(negedge clk_main_loop);
		end
		t_low = $time;
		check_bit("busy", busy, 1'b1);
		if (ps2_data_drive_low) begin
			abort_run("data was pulled low before the clock inhibit");
		end
		while (!ps2_data_drive_low) begin
			@(negedge clk_main_loop);
			if (!ps2_clk_drive_low) begin
				abort_run("clock was released before data went low");
			end
		end
		while (ps2_clk_drive_low) begin
			@(negedge clk_main_loop);
		end
		t_release = $time;
		if ((t_release - t_low) < HOLD_MIN_NS || (t_release - t_low) > HOLD_MAX_NS) begin
			abort_run($sformatf("clock inhibit lasted %0d ns, outside 119 to 121 us",
				t_release - t_low));
		end
		// host must stay off the clock once the device starts
		if (!quiet) begin
			while (!model_clk_low) begin
				@(negedge clk_main_loop);
			end
			check_bit("ps2_clk_drive_low", ps2_clk_drive_low, 1'b0);
		end
	endtask

	task automatic wait_for_done(input int start_cnt);
		int cycles;
		cycles = 0;
		while (done_cnt == start_cnt) begin
			@(negedge clk_main_loop);
			cycles++;
			if (cycles > DONE_LIMIT) begin
				abort_run("no done pulse within 3 ms of send");
			end
		end
	endtask

	// one command from send to done, optional second send while busy
	task automatic run_transfer(input logic [7:0] b, input logic ack, input logic quiet,
			input logic extra_send);
		int start_done;
		int start_frames;
		start_done   = done_cnt;
		start_frames = frame_cnt;
		@(posedge clk_main_loop);
		cmd_byte <= b;
		send     <= 1'b1;
		ack_low  <= ack;
		silent   <= quiet;
		@(posedge clk_main_loop);
		send     <= 1'b0;
		// byte must already be latched
		cmd_byte <= 8'($urandom);
		watch_request(quiet);
		check_bit("busy", busy, 1'b1);
		if (extra_send) begin
			@(posedge clk_main_loop);
			cmd_byte <= ~b;
			send     <= 1'b1;
			@(posedge clk_main_loop);
			send     <= 1'b0;
		end
		wait_for_done(start_done);
		check_result("result", res_at_done, expected_result(quiet, ack));
		if (quiet) begin
			check_bit("ps2_clk_drive_low", clk_low_at_done, 1'b0);
			check_bit("ps2_data_drive_low", data_low_at_done, 1'b0);
		end else begin
			if (frame_cnt != start_frames + 1) begin
				abort_run("device did not capture exactly one frame");
			end
			check_byte("cap_byte", cap_byte, b);
			check_bit("cap_parity", cap_parity, odd_parity(b));
			check_bit("cap_stop", cap_stop, 1'b1);
		end
		if (extra_send) begin
			// room for a restarted transfer to finish or time out
			repeat (DONE_LIMIT) @(negedge clk_main_loop);
			if (done_cnt != start_done + 1) begin
				abort_run("send during busy produced more than one done");
			end
		end
		// idle gap before the next command
		repeat ($urandom_range(2000, 10000)) @(posedge clk_main_loop);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int seed_value;
		logic [7:0] b;
		logic ack;
		seed_value = $urandom(44);
		rst_n    = 1'b0;
		cmd_byte = 8'h00;
		send     = 1'b0;
		ack_low  = 1'b1;
		silent   = 1'b0;
		repeat (2) @(posedge clk_main_loop);
		rst_n <= 1'b1;
		@(negedge clk_main_loop);
		// quiet bus after reset
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("ps2_clk_drive_low", ps2_clk_drive_low, 1'b0);
		check_bit("ps2_data_drive_low", ps2_data_drive_low, 1'b0);
		check_result("result", result, RES_OK);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			b   = 8'($urandom);
			ack = 1'($urandom);
			run_transfer(b, ack, 1'b0, 1'b0);
		end
		// silent device, ends in timeout
		run_transfer(8'($urandom), 1'b1, 1'b1, 1'b0);
		run_transfer(8'($urandom), 1'b1, 1'b0, 1'b1);
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		#(NUM_FRAMES * FRAME_NS);
		abort_run("watchdog expired, the run did not finish");
	end

endmodule

`default_nettype wire

//--- testbench/ps2_device_model.sv
////////////////////////////////////////////////////////////
// behavioral PS/2 device: clock source, frame capture, ack
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ps2_device_model (
	input  wire        ps2_clk,
	input  wire        ps2_data,
	input  wire        ack_low,
	input  wire        silent,
	output logic       clk_drive_low,
	output logic       data_drive_low,
	output logic [7:0] cap_byte,
	output logic       cap_parity,
	output logic       cap_stop,
	output int         frame_cnt
);

	// 80 us device clock period
	localparam int HALF_NS    = 40_000;
	localparam int QUARTER_NS = 20_000;
	// keeps device edges away from the main clock edges
	localparam int SKEW_NS    = 2;

	// d0 arrives first and ends up in bit 0
	logic [9:0] bits;

	// 11 device clocks, 10 host bits then the ack bit
	task automatic clock_frame();
		#(QUARTER_NS + SKEW_NS);
		for (int i = 0; i < 11; i++) begin
			clk_drive_low = 1'b1;
			#(HALF_NS);
			clk_drive_low = 1'b0;
			if (i < 9) begin
				// host changed data during the low phase
				bits = {ps2_data, bits[9:1]};
				#(HALF_NS);
			end else if (i == 9) begin
				bits       = {ps2_data, bits[9:1]};
				cap_byte   = bits[7:0];
				cap_parity = bits[8];
				cap_stop   = bits[9];
				frame_cnt  = frame_cnt + 1;
				// host releases data 10 us after this edge
				#(QUARTER_NS);
				data_drive_low = ack_low;
				#(QUARTER_NS);
			end else begin
				// ack bit taken by the host on the last fall
				data_drive_low = 1'b0;
			end
		end
	endtask

	initial begin
		clk_drive_low  = 1'b0;
		data_drive_low = 1'b0;
		cap_byte       = 8'h00;
		cap_parity     = 1'b0;
		cap_stop       = 1'b0;
		frame_cnt      = 0;
		bits           = '0;
		forever begin
			// host inhibit
			@(negedge ps2_clk);
			// clock release, data low means request to send
			@(posedge ps2_clk);
			if (!ps2_data && !silent) begin
				clock_frame();
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/ps2_host_send_top.sv
////////////////////////////////////////////////////////////
// PS/2 host send top: tick generator, timers, transmitter
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ps2_host_send_top #(
	parameter int CLKS_PER_US = 100
) (
	input  wire                 clk_main_loop,
	input  wire                 rst_n,
	input  wire  [7:0]          cmd_byte,
	input  wire                 send,
	output logic                done,
	output ps2_pkg::tx_result_e result,
	output logic                busy,
	input  wire                 ps2_clk_in,
	input  wire                 ps2_data_in,
	output logic                ps2_clk_drive_low,
	output logic                ps2_data_drive_low
);
	import timer_pkg::*;

	logic                  tick_1us;
	logic                  tick_100us;
	logic [NUM_TIMERS-1:0] timer_load;
	logic [NUM_TIMERS-1:0] timer_cancel;
	logic [NUM_TIMERS-1:0] timer_expire;
	logic [TIMER_W-1:0]    load_value;

	ps2_tick_gen #(
		.CLKS_PER_US (CLKS_PER_US)
	) u_tick_gen (
		.clk_main_loop (clk_main_loop),
		.rst_n         (rst_n),
		.tick_1us      (tick_1us),
		.tick_100us    (tick_100us)
	);

	// one timer per timer_id_e, shared load value
	for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
		// timeout counts the coarse strobe
		localparam tick_base_e BASE =
			(timer_id_e'(i) == TMR_TIMEOUT) ? TICK_100US : TICK_1US;

		ps2_interval_timer u_timer (
			.clk_main_loop (clk_main_loop),
			.rst_n         (rst_n),
			.tick          ((BASE == TICK_100US) ? tick_100us : tick_1us),
			.load          (timer_load[i]),
			.cancel        (timer_cancel[i]),
			.load_value    (load_value),
			.expire        (timer_expire[i])
		);
	end

	ps2_host_tx u_tx (
		.clk_main_loop      (clk_main_loop),
		.rst_n              (rst_n),
		.cmd_byte           (cmd_byte),
		.send               (send),
		.ps2_clk_in         (ps2_clk_in),
		.ps2_data_in        (ps2_data_in),
		.timer_expire       (timer_expire),
		.timer_load         (timer_load),
		.timer_cancel       (timer_cancel),
		.load_value         (load_value),
		.ps2_clk_drive_low  (ps2_clk_drive_low),
		.ps2_data_drive_low (ps2_data_drive_low),
		.busy               (busy),
		.done               (done),
		.result             (result)
	);

endmodule

`default_nettype wire

//--- logic/ps2_host_tx.sv
////////////////////////////////////////////////////////////
// PS/2 host send FSM with line synchronizers, frame shifter,
// acknowledge check and timer control
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ps2_host_tx (
	input  wire                              clk_main_loop,
	input  wire                              rst_n,
	input  wire  [7:0]                       cmd_byte,
	input  wire                              send,
	input  wire                              ps2_clk_in,
	input  wire                              ps2_data_in,
	input  wire  [timer_pkg::NUM_TIMERS-1:0] timer_expire,
	output logic [timer_pkg::NUM_TIMERS-1:0] timer_load,
	output logic [timer_pkg::NUM_TIMERS-1:0] timer_cancel,
	output logic [timer_pkg::TIMER_W-1:0]    load_value,
	output logic                             ps2_clk_drive_low,
	output logic                             ps2_data_drive_low,
	output logic                             busy,
	output logic                             done,
	output ps2_pkg::tx_result_e              result
);
	import ps2_pkg::*;
	import timer_pkg::*;

	ps2_state_e state;

	// [1] is the settled copy
	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_prev;
	logic       clk_fall;
	logic       clk_rise;
	logic       lines_idle;

	// stop, parity, byte; bit 0 goes out next
	logic [FRAME_BITS-1:0] frame;
	logic [3:0]            bit_cnt;
	// staggers the three timer loads at start
	logic [1:0]            load_step;

	logic phase_exp;
	logic aux_exp;
	logic timeout_exp;

	assign phase_exp   = timer_expire[TMR_PHASE];
	assign aux_exp     = timer_expire[TMR_AUX];
	assign timeout_exp = timer_expire[TMR_TIMEOUT];

	assign clk_fall   = clk_prev & ~clk_sync[1];
	assign clk_rise   = ~clk_prev & clk_sync[1];
	assign lines_idle = clk_sync[1] & data_sync[1];
	assign busy       = (state != IDLE);

	//////////////////////////////////////////////////////////
	// line synchronizers and edge register
	//////////////////////////////////////////////////////////
	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk_in};
			data_sync <= {data_sync[0], ps2_data_in};
			clk_prev  <= clk_sync[1];
		end
	end

	// value for the load pulse issued on entry to the current state
	always_comb begin
		case (state)
			INHIBIT: begin
				if (load_step == 2'd0) begin
					load_value = T_INHIBIT_US;
				end else if (load_step == 2'd1) begin
					load_value = T_DATA_LOW_US;
				end else begin
					load_value = T_TIMEOUT_100US;
				end
			end
			HOLD_LAST: load_value = T_HOLD_US;
			SETTLE:    load_value = T_SETTLE_US;
			default:   load_value = T_IDLE_US;
		endcase
	end

	// frame shifter, odd parity over the byte
	always_ff @(posedge clk_main_loop) begin
		if (state == IDLE && send) begin
			frame <= {1'b1, ~^cmd_byte, cmd_byte};
		end else if (state == WAIT_FALL && clk_fall) begin
			frame <= frame >> 1;
		end
	end

	//////////////////////////////////////////////////////////
	// send FSM
	//////////////////////////////////////////////////////////
	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			state              <= IDLE;
			ps2_clk_drive_low  <= 1'b0;
			ps2_data_drive_low <= 1'b0;
			done               <= 1'b0;
			result             <= RES_OK;
			timer_load         <= '0;
			timer_cancel       <= '0;
			load_step          <= 2'd0;
			bit_cnt            <= 4'd0;
		end else begin
			// strobes
			done         <= 1'b0;
			timer_load   <= '0;
			timer_cancel <= '0;
			if (busy && timeout_exp) begin
				// overran the 2 ms budget, drop the bus
				state              <= IDLE;
				ps2_clk_drive_low  <= 1'b0;
				ps2_data_drive_low <= 1'b0;
				result             <= RES_TIMEOUT;
				done               <= 1'b1;
				timer_cancel       <= '1;
			end else begin
				case (state)
					IDLE: begin
						if (send) begin
							state                 <= INHIBIT;
							ps2_clk_drive_low     <= 1'b1;
							timer_load[TMR_PHASE] <= 1'b1;
							load_step             <= 2'd0;
							bit_cnt               <= 4'd0;
						end
					end
					INHIBIT: begin
						if (load_step == 2'd0) begin
							timer_load[TMR_AUX] <= 1'b1;
							load_step           <= 2'd1;
						end else if (load_step == 2'd1) begin
							timer_load[TMR_TIMEOUT] <= 1'b1;
							load_step               <= 2'd2;
						end
						// data low while clock still held
						if (aux_exp) begin
							ps2_data_drive_low <= 1'b1;
							state              <= REQUEST;
						end
					end
					REQUEST: begin
						if (phase_exp) begin
							ps2_clk_drive_low <= 1'b0;
							state             <= WAIT_FALL;
						end
					end
					WAIT_FALL: begin
						// device samples on the rising edge, change while low
						if (clk_fall) begin
							ps2_data_drive_low <= ~frame[0];
							bit_cnt            <= bit_cnt + 4'd1;
							state              <= SHIFT_BIT;
						end
					end
					SHIFT_BIT: begin
						state <= (bit_cnt == FRAME_BITS) ? WAIT_LAST_RISE : WAIT_FALL;
					end
					WAIT_LAST_RISE: begin
						if (clk_rise) begin
							timer_load[TMR_PHASE] <= 1'b1;
							state                 <= HOLD_LAST;
						end
					end
					HOLD_LAST: begin
						if (phase_exp) begin
							ps2_data_drive_low <= 1'b0;
							state              <= WAIT_ACK;
						end
					end
					WAIT_ACK: begin
						// device pulls data low to acknowledge
						if (clk_fall) begin
							result                <= data_sync[1] ? RES_NO_ACK : RES_OK;
							timer_load[TMR_PHASE] <= 1'b1;
							state                 <= SETTLE;
						end
					end
					SETTLE: begin
						if (phase_exp) begin
							timer_load[TMR_PHASE] <= 1'b1;
							state                 <= WAIT_IDLE;
						end
					end
					WAIT_IDLE: begin
						// any low line restarts the idle interval
						if (!lines_idle) begin
							timer_load[TMR_PHASE] <= 1'b1;
						end else if (phase_exp) begin
							state        <= IDLE;
							done         <= 1'b1;
							timer_cancel <= '1;
						end
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// clock only held low during the request sequence
	a_clk_hold: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		ps2_clk_drive_low |-> (state inside {INHIBIT, REQUEST}));

	a_done_pulse: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		done |=> !done);

endmodule

`default_nettype wire

//--- logic/ps2_interval_timer.sv
////////////////////////////////////////////////////////////
// one-shot down-counter with load, cancel and expire
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ps2_interval_timer (
	input  wire                          clk_main_loop,
	input  wire                          rst_n,
	input  wire                          tick,
	input  wire                          load,
	input  wire                          cancel,
	input  wire [timer_pkg::TIMER_W-1:0] load_value,
	output logic                         expire
);
	import timer_pkg::*;

	logic [TIMER_W-1:0] count;
	logic               running;
	logic               last_tick;

	// zero or one left means this tick ends the interval
	assign last_tick = (count <= TIMER_W'(1));

	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			running <= 1'b0;
			expire  <= 1'b0;
		end else begin
			expire <= 1'b0;
			// load beats both cancel and tick
			if (load) begin
				running <= 1'b1;
			end else if (cancel) begin
				running <= 1'b0;
			end else if (running && tick && last_tick) begin
				running <= 1'b0;
				expire  <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_main_loop) begin
		if (load) begin
			count <= load_value;
		end else if (running && tick) begin
			count <= count - TIMER_W'(1);
		end
	end

	// expire is a single strobe per interval
	a_expire_pulse: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		expire |=> !expire);

	// cancelled interval stays quiet
	a_cancel_quiet: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		cancel |=> !expire);

endmodule

`default_nettype wire

//--- logic/ps2_tick_gen.sv
////////////////////////////////////////////////////////////
// 1 us and 100 us strobe generator
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ps2_tick_gen #(
	parameter int CLKS_PER_US = 100
) (
	input  wire  clk_main_loop,
	input  wire  rst_n,
	output logic tick_1us,
	output logic tick_100us
);

	localparam int CLK_CNT_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;
	localparam int US_PER_STEP = 100;

	logic [CLK_CNT_W-1:0] clk_cnt;
	logic [6:0]           us_cnt;
	logic                 us_wrap;
	logic                 step_wrap;

	// last main clock of the current microsecond
	assign us_wrap = (clk_cnt == CLK_CNT_W'(CLKS_PER_US - 1));
	// hundredth microsecond
	assign step_wrap = (us_cnt == 7'(US_PER_STEP - 1));

	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			clk_cnt    <= '0;
			us_cnt     <= '0;
			tick_1us   <= 1'b0;
			tick_100us <= 1'b0;
		end else begin
			tick_1us   <= us_wrap;
			tick_100us <= us_wrap && step_wrap;
			if (us_wrap) begin
				clk_cnt <= '0;
				// coarse counter only moves on the fine strobe
				us_cnt  <= step_wrap ? 7'd0 : us_cnt + 7'd1;
			end else begin
				clk_cnt <= clk_cnt + CLK_CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/timer_pkg.sv
////////////////////////////////////////////////////////////
// interval timer definitions
// timer identities, tick bases, count width
////////////////////////////////////////////////////////////
`default_nettype none

package timer_pkg;

	// one timer per job, also the bit index in the control vectors
	typedef enum logic [1:0] {
		TMR_PHASE,
		TMR_AUX,
		TMR_TIMEOUT
	} timer_id_e;

	localparam int NUM_TIMERS = 3;

	// which strobe a timer counts
	typedef enum logic {
		TICK_1US,
		TICK_100US
	} tick_base_e;

	localparam int TIMER_W = 8;

endpackage

`default_nettype wire

//--- logic/ps2_pkg.sv
////////////////////////////////////////////////////////////
// PS/2 host transmit definitions
// frame layout, FSM states, result codes, bus timing
////////////////////////////////////////////////////////////
`default_nettype none

package ps2_pkg;

	// transmitter FSM states
	typedef enum logic [3:0] {
		IDLE,
		INHIBIT,
		REQUEST,
		WAIT_FALL,
		SHIFT_BIT,
		WAIT_LAST_RISE,
		HOLD_LAST,
		WAIT_ACK,
		SETTLE,
		WAIT_IDLE
	} ps2_state_e;

	// outcome reported with done
	typedef enum logic [1:0] {
		RES_OK,
		RES_NO_ACK,
		RES_TIMEOUT
	} tx_result_e;

	// 8 data + parity + stop, start bit is the request itself
	localparam logic [3:0] FRAME_BITS = 4'd10;

	//////////////////////////////////////////////////////////
	// bus timing in microseconds
	//////////////////////////////////////////////////////////
	localparam logic [7:0] T_INHIBIT_US  = 8'd120;
	localparam logic [7:0] T_DATA_LOW_US = 8'd60;
	localparam logic [7:0] T_HOLD_US     = 8'd10;
	localparam logic [7:0] T_SETTLE_US   = 8'd60;
	localparam logic [7:0] T_IDLE_US     = 8'd20;

	// whole transfer limit, 100 us units -> 2 ms
	localparam logic [7:0] T_TIMEOUT_100US = 8'd20;

endpackage

`default_nettype wire
